/* include/calu_defs.svh */
`ifndef CALU_DEFS_SVH
`define CALU_DEFS_SVH

////////////////////////////////////////////////////////////
// sample widths
////////////////////////////////////////////////////////////

// one Q15 part, real or imag
`define CALU_PART_W 16

// packed re/im sample, also the result word
`define CALU_WORD_W 32

////////////////////////////////////////////////////////////
// dsp slice ports
////////////////////////////////////////////////////////////

`define CALU_PORTA_W 18 // multiplier a input
`define CALU_PORTB_W 18 // multiplier b input
`define CALU_ACC_W   48 // c port and accumulator

////////////////////////////////////////////////////////////
// pipeline depths
////////////////////////////////////////////////////////////

// input reg, product reg, accumulator reg
`define CALU_SLICE_LAT 3

// mapper + slice + combiner, operand in to result out
`define CALU_LAT 5

`endif

/* project.f */
+incdir+include
src/calu_pkg.sv
src/stage_delay.sv
src/dsp_slice.sv
src/operand_map.sv
src/complex_alu.sv
src/calu_top.sv
testbench/calu_ref_pkg.sv
testbench/calu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the complex alu testbench with verilator
# exit status is the simulation result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	-f project.f \
	--top-module calu_tb \
	-Mdir obj_dir \
	-o calu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/calu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

echo "simulation exited cleanly"
exit 0

/* src/calu_pkg.sv */
`include "calu_defs.svh"

package calu_pkg;

	////////////////////////////////////////////////////////////
	// opcodes
	////////////////////////////////////////////////////////////

	// 0..3 are undefined and decode as mul
	typedef enum logic [2:0] {
		OP_MUL     = 3'd4, // x*y
		OP_MULADD  = 3'd5, // x*y + w
		OP_MULCONJ = 3'd6, // conj(x)*y
		OP_MAXPOW  = 3'd7  // larger of |x|^2, |y|^2
	} calu_op_e;

	////////////////////////////////////////////////////////////
	// samples
	////////////////////////////////////////////////////////////

	// re sits in the upper half of the word
	typedef struct packed {
		logic signed [`CALU_PART_W-1:0] re;
		logic signed [`CALU_PART_W-1:0] im;
	} cplx_t;

	typedef logic [`CALU_WORD_W-1:0] calu_word_t; // raw result

	////////////////////////////////////////////////////////////
	// slice ports
	////////////////////////////////////////////////////////////

	// inputs of one multiply-accumulate slice
	typedef struct packed {
		logic signed [`CALU_PORTA_W-1:0] a; // multiplicand
		logic signed [`CALU_PORTB_W-1:0] b; // multiplier
		logic signed [`CALU_ACC_W-1:0]   c; // addend, product scale
		logic                            add_c; // c joins the sum
	} slice_in_t;

	// index 0 is slice 1
	typedef slice_in_t [3:0] slice_set_t;

	// how the combiner folds p1..p4
	typedef enum logic [1:0] {
		COMB_MUL  = 2'd0, // re = p1-p2, im = p3+p4
		COMB_CONJ = 2'd1, // re = p1+p2, im = p3-p4
		COMB_POW  = 2'd2  // max(p1+p2, p3+p4)
	} comb_mode_e;

endpackage

/* src/calu_top.sv */
`timescale 1ns/1ps

// complex alu top: operand mapper feeding the slice pipeline
// one op per clock, result five clocks later
module calu_top (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 valid_i,
	input  calu_pkg::calu_op_e   op_i,
	input  calu_pkg::cplx_t      x_i,
	input  calu_pkg::cplx_t      y_i,
	input  calu_pkg::cplx_t      w_i,
	output logic                 valid_o,
	output calu_pkg::calu_word_t result_o
);

	import calu_pkg::*;

	logic       map_valid;  // mapper output strobe
	slice_set_t map_slices; // per slice a, b, c, add_c
	comb_mode_e map_mode;   // how to fold the products

	////////////////////////////////////////////////////////////
	// producer
	////////////////////////////////////////////////////////////

	operand_map u_map (
		.clk      (clk),
		.rst_i    (rst_i),
		.valid_i  (valid_i),
		.op_i     (op_i),
		.x_i      (x_i),
		.y_i      (y_i),
		.w_i      (w_i),
		.valid_o  (map_valid),
		.slices_o (map_slices),
		.mode_o   (map_mode)
	);

	////////////////////////////////////////////////////////////
	// consumer
	////////////////////////////////////////////////////////////

	complex_alu u_alu (
		.clk      (clk),
		.rst_i    (rst_i),
		.valid_i  (map_valid),
		.slices_i (map_slices),
		.mode_i   (map_mode),
		.valid_o  (valid_o),
		.result_o (result_o)
	);

endmodule

/* src/complex_alu.sv */
`timescale 1ns/1ps
`include "calu_defs.svh"

// four mac slices plus the result combiner
// control rides along in delay lines matched to the slice latency
module complex_alu (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   valid_i,
	input  calu_pkg::slice_set_t   slices_i,
	input  calu_pkg::comb_mode_e   mode_i,
	output logic                   valid_o,
	output calu_pkg::calu_word_t   result_o
);

	import calu_pkg::*;

	localparam int LO = `CALU_PART_W - 1;   // lowest kept bit of a part
	localparam int HI = 2*`CALU_PART_W - 2; // highest kept bit, drops the extra sign

	logic signed [`CALU_ACC_W-1:0] p [4]; // slice outputs, p[0] is p1
	comb_mode_e                    mode_d; // mode lined up with p
	logic signed [`CALU_ACC_W-1:0] sum_a; // re, or s1 for power
	logic signed [`CALU_ACC_W-1:0] sum_b; // im, or s2 for power
	calu_word_t                    result_n;

	////////////////////////////////////////////////////////////
	// slices
	////////////////////////////////////////////////////////////

	for (genvar gi = 0; gi < 4; gi++) begin : g_slice
		dsp_slice u_slice (
			.clk   (clk),
			.rst_i (rst_i),
			.in_i  (slices_i[gi]),
			.p_o   (p[gi])
		);
	end

	////////////////////////////////////////////////////////////
	// control delay
	////////////////////////////////////////////////////////////

	// mode arrives with the accumulator outputs
	stage_delay #(
		.T     (comb_mode_e),
		.DEPTH (`CALU_SLICE_LAT)
	) u_mode_dly (
		.clk   (clk),
		.rst_i (rst_i),
		.d_i   (mode_i),
		.q_o   (mode_d)
	);

	// one extra stage covers the combiner register
	stage_delay #(
		.T     (logic),
		.DEPTH (`CALU_SLICE_LAT + 1)
	) u_valid_dly (
		.clk   (clk),
		.rst_i (rst_i),
		.d_i   (valid_i),
		.q_o   (valid_o)
	);

	////////////////////////////////////////////////////////////
	// combiner
	////////////////////////////////////////////////////////////

	always_comb begin
		// real side: ac-bd for mul, ac+bd for conj, a2+b2 for power
		if (mode_d == COMB_MUL)
			sum_a = p[0] - p[1];
		else
			sum_a = p[0] + p[1];

		// imag side: ad-bc only for conj
		if (mode_d == COMB_CONJ)
			sum_b = p[2] - p[3];
		else
			sum_b = p[2] + p[3];

		if (mode_d == COMB_POW) begin
			// ties go to s2
			if (sum_a > sum_b)
				result_n = sum_a[`CALU_WORD_W-1:0];
			else
				result_n = sum_b[`CALU_WORD_W-1:0];
		end else begin
			// Q30 back to Q15, same as doubling and keeping the top half
			result_n = {sum_a[HI:LO], sum_b[HI:LO]};
		end
	end

	always_ff @(posedge clk) begin
		result_o <= result_n; // no reset, qualified by valid_o
	end

endmodule

/* src/dsp_slice.sv */
`timescale 1ns/1ps
`include "calu_defs.svh"

// one multiply-accumulate slice, same staging as a dsp block
// p = a*b (+ c), three register stages
module dsp_slice (
	input  logic                          clk,
	input  logic                          rst_i,
	input  calu_pkg::slice_in_t           in_i,
	output logic signed [`CALU_ACC_W-1:0] p_o
);

	localparam int PROD_W = `CALU_PORTA_W + `CALU_PORTB_W; // full product width
	localparam int EXT_W  = `CALU_ACC_W - PROD_W;          // sign bits up to acc width

	////////////////////////////////////////////////////////////
	// stage 1, input registers
	////////////////////////////////////////////////////////////

	logic signed [`CALU_PORTA_W-1:0] a_q;
	logic signed [`CALU_PORTB_W-1:0] b_q;
	logic signed [`CALU_ACC_W-1:0]   c_q;
	logic                            add_c_q; // c enable, follows stage 1

	always_ff @(posedge clk) begin
		a_q <= in_i.a;
		b_q <= in_i.b;
		c_q <= in_i.c;
	end

	// only the config bit is control, clear it
	always_ff @(posedge clk) begin
		if (rst_i)
			add_c_q <= 1'b0;
		else
			add_c_q <= in_i.add_c;
	end

	////////////////////////////////////////////////////////////
	// stage 2, product and c registers
	////////////////////////////////////////////////////////////

	logic signed [PROD_W-1:0]      m_q; // a*b, full precision
	logic signed [`CALU_ACC_W-1:0] cm_q; // c or zero

	always_ff @(posedge clk) begin
		m_q <= a_q * b_q; // signed 18x18
		if (add_c_q)
			cm_q <= c_q;
		else
			cm_q <= '0; // plain multiply
	end

	////////////////////////////////////////////////////////////
	// stage 3, accumulator
	////////////////////////////////////////////////////////////

	logic signed [`CALU_ACC_W-1:0] m_ext;
	logic signed [`CALU_ACC_W-1:0] p_q;

	assign m_ext = {{EXT_W{m_q[PROD_W-1]}}, m_q}; // sign extend product

	always_ff @(posedge clk) begin
		p_q <= m_ext + cm_q; // multiply-add, wraps at 48 bits
	end

	assign p_o = p_q;

endmodule

/* src/operand_map.sv */
`timescale 1ns/1ps
`include "calu_defs.svh"

// decodes the opcode and routes the sample parts to the four slices
// x = a + jb, y = c + jd, w feeds the c ports
module operand_map (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   valid_i,
	input  calu_pkg::calu_op_e     op_i,
	input  calu_pkg::cplx_t        x_i,
	input  calu_pkg::cplx_t        y_i,
	input  calu_pkg::cplx_t        w_i,
	output logic                   valid_o,
	output calu_pkg::slice_set_t   slices_o,
	output calu_pkg::comb_mode_e   mode_o
);

	import calu_pkg::*;

	slice_set_t slices_n;
	comb_mode_e mode_n;

	// sign extend two parts onto a/b and one onto c
	function automatic slice_in_t pack_slice(
		input logic signed [`CALU_PART_W-1:0] ma,
		input logic signed [`CALU_PART_W-1:0] mb,
		input logic signed [`CALU_PART_W-1:0] cv,
		input logic                           en
	);
		slice_in_t s;
		s.a     = {{(`CALU_PORTA_W - `CALU_PART_W){ma[`CALU_PART_W-1]}}, ma};
		s.b     = {{(`CALU_PORTB_W - `CALU_PART_W){mb[`CALU_PART_W-1]}}, mb};
		s.c     = {{(`CALU_ACC_W - `CALU_PART_W){cv[`CALU_PART_W-1]}}, cv};
		s.add_c = en;
		return s;
	endfunction

	always_comb begin
		// default map: ac, bd, ad, bc with no addend
		slices_n[0] = pack_slice(x_i.re, y_i.re, w_i.re, 1'b0);
		slices_n[1] = pack_slice(x_i.im, y_i.im, '0, 1'b0);
		slices_n[2] = pack_slice(x_i.re, y_i.im, w_i.im, 1'b0);
		slices_n[3] = pack_slice(x_i.im, y_i.re, '0, 1'b0);
		mode_n      = COMB_MUL;
		case (op_i)
			OP_MULADD: begin
				slices_n[0].add_c = 1'b1; // ac + w.re
				slices_n[2].add_c = 1'b1; // ad + w.im
			end
			OP_MULCONJ: mode_n = COMB_CONJ; // same products, signs flip
			OP_MAXPOW: begin
				slices_n[0] = pack_slice(x_i.re, x_i.re, '0, 1'b0); // a*a
				slices_n[1] = pack_slice(x_i.im, x_i.im, '0, 1'b0); // b*b
				slices_n[2] = pack_slice(y_i.im, y_i.im, '0, 1'b0); // d*d
				slices_n[3] = pack_slice(y_i.re, y_i.re, '0, 1'b0); // c*c
				mode_n      = COMB_POW;
			end
			default: ; // mul, and the undefined codes
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i;
	end

	// payload, meaningful only with valid_o
	always_ff @(posedge clk) begin
		slices_o <= slices_n;
		mode_o   <= mode_n;
	end

endmodule

/* src/stage_delay.sv */
`timescale 1ns/1ps

// shift register for any payload type
module stage_delay #(
	parameter type T     = logic,
	parameter int  DEPTH = 1
) (
	input  logic clk,
	input  logic rst_i,
	input  T     d_i,
	output T     q_o
);

	T pipe [DEPTH]; // pipe[0] is the newest entry

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < DEPTH; i++) begin
				pipe[i] <= T'('0); // all stages back to zero
			end
		end else begin
			pipe[0] <= d_i;
			for (int i = 1; i < DEPTH; i++) begin
				pipe[i] <= pipe[i-1]; // shift one stage on
			end
		end
	end

	assign q_o = pipe[DEPTH-1]; // oldest entry

endmodule

/* testbench/calu_ref_pkg.sv */
`include "calu_defs.svh"

// expected results, worked straight from the arithmetic of each operation
package calu_ref_pkg;

	import calu_pkg::*;

	// Q30 sum to a Q15 part, keeps bits 30:15 and wraps
	function automatic logic [`CALU_PART_W-1:0] scale_part(input longint sum);
		logic [63:0] raw;
		raw = sum;
		return raw[2*`CALU_PART_W-2 -: `CALU_PART_W];
	endfunction

	// expected result word for one operation
	// x = a + jb, y = c + jd
	function automatic calu_word_t calc_result(
		input calu_op_e op,
		input cplx_t    x,
		input cplx_t    y,
		input cplx_t    w
	);
		longint      a;
		longint      b;
		longint      c;
		longint      d;
		longint      re_sum;
		longint      im_sum;
		longint      s1;
		longint      s2;
		logic [63:0] pick;
		a = $signed(x.re);
		b = $signed(x.im);
		c = $signed(y.re);
		d = $signed(y.im);
		s1 = a*a + b*b; // |x|^2
		s2 = c*c + d*d; // |y|^2
		pick = (s1 > s2) ? s1 : s2; // a tie gives s2
		case (op)
			OP_MULADD: begin
				// addend enters at product scale
				re_sum = a*c + longint'($signed(w.re)) - b*d;
				im_sum = a*d + longint'($signed(w.im)) + b*c;
			end
			OP_MULCONJ: begin
				re_sum = a*c + b*d;
				im_sum = a*d - b*c;
			end
			OP_MAXPOW: return pick[`CALU_WORD_W-1:0];
			default: begin // mul and undefined codes
				re_sum = a*c - b*d;
				im_sum = a*d + b*c;
			end
		endcase
		return {scale_part(re_sum), scale_part(im_sum)};
	endfunction

endpackage

/* testbench/calu_tb.sv */
`timescale 1ns/1ps
`include "calu_defs.svh"

module calu_tb;

	import calu_pkg::*;
	import calu_ref_pkg::*;

	localparam int RESET_CYC = 3;
	localparam int MAX_GAP   = 3; // longest idle run in the mixed phase
	localparam int N_MUL     = 100;
	localparam int N_ADD     = 60;
	localparam int N_CONJ    = 50;
	localparam int N_POW     = 50;
	localparam int N_MIX     = 200;
	// 13 directed cases on top of the random ones
	localparam int N_OPS       = 13 + N_MUL + N_ADD + N_CONJ + N_POW + N_MIX;
	localparam int TIMEOUT_CYC = RESET_CYC + 2 + N_OPS + N_MIX*MAX_GAP + `CALU_LAT + 20;

	logic       clk = 1'b0;
	logic       rst_i;
	logic       valid_i;
	calu_op_e   op_i;
	cplx_t      x_i;
	cplx_t      y_i;
	cplx_t      w_i;
	logic       valid_o;
	calu_word_t result_o;

	int         cyc = 0; // rising edges so far
	string      test_name = "reset";
	calu_word_t exp_q[$]; // expected words, oldest first
	calu_op_e   op_q[$];
	int         stamp_q[$]; // edge on which the op was driven
	string      name_q[$];

	calu_top dut_i (
		.clk      (clk),
		.rst_i    (rst_i),
		.valid_i  (valid_i),
		.op_i     (op_i),
		.x_i      (x_i),
		.y_i      (y_i),
		.w_i      (w_i),
		.valid_o  (valid_o),
		.result_o (result_o)
	);

	always #5 clk = ~clk; // 10 ns period

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("Testbench failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_cplx(input string name, input cplx_t exp_v, input cplx_t act_v);
		if (act_v !== exp_v) begin
			$display("FAILED %s: expected re=%0d im=%0d, actual re=%0d im=%0d",
				name, exp_v.re, exp_v.im, act_v.re, act_v.im);
			stop_run();
		end
	endtask

	task automatic check_power(input string name, input calu_word_t exp_v,
		input calu_word_t act_v);
		if (act_v !== exp_v) begin
			$display("FAILED %s: expected %h, actual %h", name, exp_v, act_v);
			stop_run();
		end
	endtask

	function automatic cplx_t make_cplx(input logic [15:0] re, input logic [15:0] im);
		return {re, im};
	endfunction

	function automatic cplx_t rand_sample();
		return cplx_t'($urandom);
	endfunction

	// one op on the next rising edge
	task automatic issue_op(input calu_op_e op, input cplx_t x, input cplx_t y, input cplx_t w);
		@(posedge clk);
		valid_i <= 1'b1;
		op_i    <= op;
		x_i     <= x;
		y_i     <= y;
		w_i     <= w;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			valid_i <= 1'b0;
		end
	endtask

	task automatic random_ops(input calu_op_e op, input int n);
		repeat (n) issue_op(op, rand_sample(), rand_sample(), rand_sample());
	endtask

	////////////////////////////////////////////////////////////
	// cycle count and timeout
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYC) begin
			$display("timeout after %0d cycles, %0d results outstanding", cyc, exp_q.size());
			stop_run();
		end
	end

	// compare first, then record whatever was driven on the last edge
	always @(negedge clk) begin
		if (valid_o === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("valid_o went high with no operation outstanding");
				stop_run();
			end else begin
				if (cyc - stamp_q[0] != `CALU_LAT) begin
					$display("FAILED %s latency: expected %0d, actual %0d",
						name_q[0], `CALU_LAT, cyc - stamp_q[0]);
					stop_run();
				end
				if (op_q[0] == OP_MAXPOW)
					check_power(name_q[0], exp_q[0], result_o);
				else
					check_cplx(name_q[0], cplx_t'(exp_q[0]), cplx_t'(result_o));
				void'(exp_q.pop_front());
				void'(op_q.pop_front());
				void'(stamp_q.pop_front());
				void'(name_q.pop_front());
			end
		end else if (valid_o !== 1'b0) begin
			$display("valid_o is unknown at cycle %0d", cyc);
			stop_run();
		end
		if (valid_i === 1'b1) begin
			exp_q.push_back(calc_result(op_i, x_i, y_i, w_i));
			op_q.push_back(op_i);
			stamp_q.push_back(cyc);
			name_q.push_back(test_name);
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	initial begin
		cplx_t      xv;
		logic [2:0] code;
		rst_i   = 1'b1;
		valid_i = 1'b0;
		op_i    = OP_MUL;
		x_i     = '0;
		y_i     = '0;
		w_i     = '0;
		void'($urandom(1));
		repeat (RESET_CYC) @(posedge clk);
		rst_i <= 1'b0;
		idle_cycles(2); // valid_o must stay low here too

		test_name = "mul_directed";
		issue_op(OP_MUL, make_cplx(16'h4000, 16'h0), make_cplx(16'h4000, 16'h0), '0);
		issue_op(OP_MUL, make_cplx(16'h8000, 16'h0), make_cplx(16'h8000, 16'h0), '0); // wraps
		issue_op(OP_MUL, make_cplx(16'h0, 16'h7fff), make_cplx(16'h0, 16'h7fff), '0); // j*j
		test_name = "mul_random";
		random_ops(OP_MUL, N_MUL);

		test_name = "muladd_random";
		random_ops(OP_MULADD, N_ADD);
		test_name = "muladd_wrap"; // addend alone tips re over full scale
		issue_op(OP_MULADD, make_cplx(16'h8000, 16'hffff), make_cplx(16'h8001, 16'h0001),
			make_cplx(16'h7fff, 16'h0000)); // re +1 wraps to -1
		issue_op(OP_MULADD, make_cplx(16'h8000, 16'h0001), make_cplx(16'h7fff, 16'h0001),
			make_cplx(16'h8000, 16'h8000)); // re -1 wraps to +1

		test_name = "conj_random";
		random_ops(OP_MULCONJ, N_CONJ);
		test_name = "conj_equal"; // imag part must be zero
		repeat (4) begin
			xv = rand_sample();
			issue_op(OP_MULCONJ, xv, xv, rand_sample());
		end

		test_name = "maxpow_random";
		random_ops(OP_MAXPOW, N_POW);
		test_name = "maxpow_equal";
		issue_op(OP_MAXPOW, make_cplx(16'd3, 16'd4), make_cplx(16'd4, 16'd3), '0);
		issue_op(OP_MAXPOW, make_cplx(16'h1234, 16'hff00), make_cplx(16'h0100, 16'hedcc), '0);
		test_name = "maxpow_fullscale";
		issue_op(OP_MAXPOW, make_cplx(16'h8000, 16'h0), make_cplx(16'h7fff, 16'h7fff), '0);
		issue_op(OP_MAXPOW, make_cplx(16'h8000, 16'h8000), make_cplx(16'h7fff, 16'h0), '0);

		// random codes, undefined ones included, with idle runs
		test_name = "mixed";
		repeat (N_MIX) begin
			code = 3'($urandom_range(7, 0));
			issue_op(calu_op_e'(code), rand_sample(), rand_sample(), rand_sample());
			if ($urandom_range(3, 0) == 0)
				idle_cycles($urandom_range(MAX_GAP, 1));
		end

		idle_cycles(`CALU_LAT + 2); // last result drains
		if (exp_q.size() != 0) begin
			$display("%0d operations never produced a result", exp_q.size());
			stop_run();
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule
